// ==== Bender.yml ====
package:
  name: mpls_egress

sources:
  - files:
      - logic/mpls_egress_pkg.sv
      - logic/mpls_label_pkg.sv
      - logic/mpls_label_edit.sv
      - logic/mpls_egress_demux.sv
      - logic/mpls_egress_port_buf.sv
      - logic/mpls_egress_downsize.sv
      - logic/mpls_egress_port_group.sv
      - logic/mpls_egress.sv
  - target: test
    files:
      - testbench/mpls_egress_tb.sv

// ==== all.f ====
logic/mpls_egress_pkg.sv
logic/mpls_label_pkg.sv
logic/mpls_label_edit.sv
logic/mpls_egress_demux.sv
logic/mpls_egress_port_buf.sv
logic/mpls_egress_downsize.sv
logic/mpls_egress_port_group.sv
logic/mpls_egress.sv
testbench/mpls_egress_tb.sv

// ==== logic/mpls_egress.sv ====
// MPLS router egress stage
// Label edit, port demux and per-width port groups

`timescale 1ns/1ps
`default_nettype none

module mpls_egress (
    input  wire logic                                   clk,
    input  wire logic                                   rst_n,
    input  wire logic                                   in_valid,
    output logic                                        in_ready,
    input  wire logic [mpls_egress_pkg::BUS_W-1:0]      in_data,
    input  wire logic                                   in_last,
    input  wire logic [mpls_egress_pkg::PORT_SEL_W-1:0] in_port,
    output logic [1:0]                                  wide_valid,
    input  wire logic [1:0]                             wide_ready,
    output logic [127:0]                                wide_data,
    output logic [1:0]                                  wide_last,
    output logic [1:0]                                  narrow_valid,
    input  wire logic [1:0]                             narrow_ready,
    output logic [31:0]                                 narrow_data,
    output logic [1:0]                                  narrow_last,
    output logic [3:0]                                  overflow
);

    localparam int NW = mpls_egress_pkg::NUM_WIDE_PORTS;
    localparam int NN = mpls_egress_pkg::NUM_NARROW_PORTS;

    logic                                     edit_valid;
    logic                                     edit_ready;
    logic [mpls_egress_pkg::BUS_W-1:0]        edit_data;
    logic                                     edit_last;
    logic [mpls_egress_pkg::PORT_SEL_W-1:0]   edit_port;
    logic [mpls_egress_pkg::NUM_PORTS-1:0]    buf_valid;
    logic [mpls_egress_pkg::BUS_W-1:0]        buf_data;
    logic                                     buf_last;
    logic                                     buf_first;

    //////////////////////////////////////////////////
    // Label edit and demux
    mpls_label_edit u_label_edit (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .in_valid   ( in_valid   ),
        .in_ready   ( in_ready   ),
        .in_data    ( in_data    ),
        .in_last    ( in_last    ),
        .in_port    ( in_port    ),
        .edit_valid ( edit_valid ),
        .edit_ready ( edit_ready ),
        .edit_data  ( edit_data  ),
        .edit_last  ( edit_last  ),
        .edit_port  ( edit_port  )
    );

    mpls_egress_demux u_demux (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .edit_valid ( edit_valid ),
        .edit_ready ( edit_ready ),
        .edit_data  ( edit_data  ),
        .edit_last  ( edit_last  ),
        .edit_port  ( edit_port  ),
        .buf_valid  ( buf_valid  ),
        .buf_data   ( buf_data   ),
        .buf_last   ( buf_last   ),
        .buf_first  ( buf_first  )
    );

    //////////////////////////////////////////////////
    // Port groups, wide ports first
    mpls_egress_port_group #(
        .NUM_GROUP_PORTS ( NW                          ),
        .OUT_BYTES       ( mpls_egress_pkg::BUS_BYTES  )
    ) u_wide_group (
        .clk       ( clk                   ),
        .rst_n     ( rst_n                 ),
        .buf_valid ( buf_valid[NW-1:0]     ),
        .buf_data  ( buf_data              ),
        .buf_last  ( buf_last              ),
        .buf_first ( buf_first             ),
        .out_valid ( wide_valid            ),
        .out_ready ( wide_ready            ),
        .out_data  ( wide_data             ),
        .out_last  ( wide_last             ),
        .overflow  ( overflow[NW-1:0]      )
    );

    mpls_egress_port_group #(
        .NUM_GROUP_PORTS ( NN                            ),
        .OUT_BYTES       ( mpls_egress_pkg::NARROW_BYTES )
    ) u_narrow_group (
        .clk       ( clk                     ),
        .rst_n     ( rst_n                   ),
        .buf_valid ( buf_valid[NW +: NN]     ),
        .buf_data  ( buf_data                ),
        .buf_last  ( buf_last                ),
        .buf_first ( buf_first               ),
        .out_valid ( narrow_valid            ),
        .out_ready ( narrow_ready            ),
        .out_data  ( narrow_data             ),
        .out_last  ( narrow_last             ),
        .overflow  ( overflow[NW +: NN]      )
    );

endmodule

`default_nettype wire

// ==== logic/mpls_egress_demux.sv ====
// Egress demux
// Steers whole packets to the port named on their first beat

`timescale 1ns/1ps
`default_nettype none

module mpls_egress_demux (
    input  wire logic                                   clk,
    input  wire logic                                   rst_n,
    input  wire logic                                   edit_valid,
    output logic                                        edit_ready,
    input  wire logic [mpls_egress_pkg::BUS_W-1:0]      edit_data,
    input  wire logic                                   edit_last,
    input  wire logic [mpls_egress_pkg::PORT_SEL_W-1:0] edit_port,
    output logic [mpls_egress_pkg::NUM_PORTS-1:0]       buf_valid,
    output logic [mpls_egress_pkg::BUS_W-1:0]           buf_data,
    output logic                                        buf_last,
    output logic                                        buf_first
);

    logic                                     sop;
    logic [mpls_egress_pkg::PORT_SEL_W-1:0]   port_q;
    logic [mpls_egress_pkg::PORT_SEL_W-1:0]   port_sel;

    // Buffers admit or drop on their own, never back-pressure
    assign edit_ready = 1'b1;

    // Later beats follow the port locked at start of packet
    assign port_sel  = sop ? edit_port : port_q;
    assign buf_first = edit_valid && sop;
    assign buf_data  = edit_data;
    assign buf_last  = edit_last;

    always_comb begin
        for (int i = 0; i < mpls_egress_pkg::NUM_PORTS; i++) begin
            buf_valid[i] = edit_valid && (port_sel == i);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sop    <= 1'b1;
            port_q <= '0;
        end else if (edit_valid) begin
            sop <= edit_last;
            if (sop) begin
                port_q <= edit_port;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/mpls_egress_downsize.sv ====
// Egress width converter
// Splits each wide beat into narrow slices, least significant first

`timescale 1ns/1ps
`default_nettype none

module mpls_egress_downsize (
    input  wire logic                                              clk,
    input  wire logic                                              rst_n,
    input  wire logic                                              wide_valid,
    output logic                                                   wide_ready,
    input  wire logic [mpls_egress_pkg::BUS_W-1:0]                 wide_data,
    input  wire logic                                              wide_last,
    output logic                                                   narrow_valid,
    input  wire logic                                              narrow_ready,
    output logic [mpls_egress_pkg::NARROW_BYTES*8-1:0]             narrow_data,
    output logic                                                   narrow_last
);

    localparam int NARROW_W = mpls_egress_pkg::NARROW_BYTES * 8;
    localparam int SLICES   = mpls_egress_pkg::BUS_BYTES / mpls_egress_pkg::NARROW_BYTES;
    localparam int SLICE_W  = $clog2(SLICES);

    logic [mpls_egress_pkg::BUS_W-1:0]   wide_q;
    logic                                last_q;
    logic                                held;
    logic [SLICE_W-1:0]                  slice;
    logic                                final_slice;

    // One wide beat in flight at a time
    assign wide_ready   = !held;
    assign narrow_valid = held;
    assign final_slice  = (slice == SLICE_W'(SLICES - 1));
    assign narrow_data  = wide_q[slice*NARROW_W +: NARROW_W];
    assign narrow_last  = last_q && final_slice;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            held  <= 1'b0;
            slice <= '0;
        end else if (wide_valid && wide_ready) begin
            held  <= 1'b1;
            slice <= '0;
        end else if (narrow_valid && narrow_ready) begin
            slice <= slice + 1'b1;
            if (final_slice) begin
                held <= 1'b0;
            end
        end
    end

    // Payload capture
    always_ff @(posedge clk) begin
        if (wide_valid && wide_ready) begin
            wide_q <= wide_data;
            last_q <= wide_last;
        end
    end

endmodule

`default_nettype wire

// ==== logic/mpls_egress_pkg.sv ====
// MPLS egress constants
// Stream geometry, port map and port buffer sizing

`default_nettype none

package mpls_egress_pkg;

    //////////////////////////////////////////////////
    // Wide stream
    localparam int BUS_BYTES = 8;
    localparam int BUS_W     = 64;

    //////////////////////////////////////////////////
    // Physical ports
    // Wide ports come first, then the narrow ones
    localparam int NUM_PORTS        = 4;
    localparam int PORT_SEL_W       = 2;
    localparam int NUM_WIDE_PORTS   = 2;
    localparam int NARROW_BYTES     = 2;
    localparam int NUM_NARROW_PORTS = 2;

    //////////////////////////////////////////////////
    // Port buffers, sized in wide beats
    localparam int BUF_DEPTH     = 16;
    localparam int MAX_PKT_BEATS = 4;
    localparam int BUF_CNT_W     = 5;

endpackage

`default_nettype wire

// ==== logic/mpls_egress_port_buf.sv ====
// Egress port buffer
// Packet FIFO that admits only whole packets and flags congestion drops

`timescale 1ns/1ps
`default_nettype none

module mpls_egress_port_buf (
    input  wire logic                              clk,
    input  wire logic                              rst_n,
    input  wire logic                              wr_valid,
    input  wire logic [mpls_egress_pkg::BUS_W-1:0] wr_data,
    input  wire logic                              wr_last,
    input  wire logic                              wr_first,
    output logic                                   rd_valid,
    input  wire logic                              rd_ready,
    output logic [mpls_egress_pkg::BUS_W-1:0]      rd_data,
    output logic                                   rd_last,
    output logic                                   overflow
);

    localparam int DEPTH = mpls_egress_pkg::BUF_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam logic [mpls_egress_pkg::BUF_CNT_W-1:0] ADMIT_MAX =
        mpls_egress_pkg::BUF_CNT_W'(DEPTH - mpls_egress_pkg::MAX_PKT_BEATS);

    logic [mpls_egress_pkg::BUS_W:0]         mem [DEPTH];
    logic [PTR_W-1:0]                        wr_ptr;
    logic [PTR_W-1:0]                        rd_ptr;
    logic [mpls_egress_pkg::BUF_CNT_W-1:0]   count;
    logic                                    admit_q;
    logic                                    admit_now;
    logic                                    wr_en;
    logic                                    rd_en;

    // Admit a packet only when room for a largest packet remains
    assign admit_now = wr_first ? (count <= ADMIT_MAX) : admit_q;
    assign wr_en     = wr_valid && admit_now;

    assign rd_valid  = (count != '0);
    assign rd_en     = rd_valid && rd_ready;
    assign rd_data   = mem[rd_ptr][mpls_egress_pkg::BUS_W-1:0];
    assign rd_last   = mem[rd_ptr][mpls_egress_pkg::BUS_W];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            admit_q  <= 1'b0;
            overflow <= 1'b0;
        end else begin
            // Drop flag follows the refused first beat by one cycle
            overflow <= wr_valid && wr_first && !admit_now;
            if (wr_valid && wr_first) begin
                admit_q <= admit_now;
            end
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (wr_en ? 1'b1 : 1'b0) - (rd_en ? 1'b1 : 1'b0);
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= {wr_last, wr_data};
        end
    end

endmodule

`default_nettype wire

// ==== logic/mpls_egress_port_group.sv ====
// Egress port group
// Buffers for ports of one width, with downsizers on narrow groups

`timescale 1ns/1ps
`default_nettype none

module mpls_egress_port_group #(
    parameter int NUM_GROUP_PORTS = 2,
    parameter int OUT_BYTES       = 8
) (
    input  wire logic                                  clk,
    input  wire logic                                  rst_n,
    input  wire logic [NUM_GROUP_PORTS-1:0]            buf_valid,
    input  wire logic [mpls_egress_pkg::BUS_W-1:0]     buf_data,
    input  wire logic                                  buf_last,
    input  wire logic                                  buf_first,
    output logic [NUM_GROUP_PORTS-1:0]                 out_valid,
    input  wire logic [NUM_GROUP_PORTS-1:0]            out_ready,
    output logic [NUM_GROUP_PORTS*OUT_BYTES*8-1:0]     out_data,
    output logic [NUM_GROUP_PORTS-1:0]                 out_last,
    output logic [NUM_GROUP_PORTS-1:0]                 overflow
);

    localparam int OUT_W = OUT_BYTES * 8;

    for (genvar i = 0; i < NUM_GROUP_PORTS; i++) begin : g_port
        logic                              rd_valid;
        logic                              rd_ready;
        logic [mpls_egress_pkg::BUS_W-1:0] rd_data;
        logic                              rd_last;

        mpls_egress_port_buf u_buf (
            .clk      ( clk          ),
            .rst_n    ( rst_n        ),
            .wr_valid ( buf_valid[i] ),
            .wr_data  ( buf_data     ),
            .wr_last  ( buf_last     ),
            .wr_first ( buf_first    ),
            .rd_valid ( rd_valid     ),
            .rd_ready ( rd_ready     ),
            .rd_data  ( rd_data      ),
            .rd_last  ( rd_last      ),
            .overflow ( overflow[i]  )
        );

        if (OUT_BYTES < mpls_egress_pkg::BUS_BYTES) begin : g_narrow
            mpls_egress_downsize u_downsize (
                .clk          ( clk                         ),
                .rst_n        ( rst_n                       ),
                .wide_valid   ( rd_valid                    ),
                .wide_ready   ( rd_ready                    ),
                .wide_data    ( rd_data                     ),
                .wide_last    ( rd_last                     ),
                .narrow_valid ( out_valid[i]                ),
                .narrow_ready ( out_ready[i]                ),
                .narrow_data  ( out_data[i*OUT_W +: OUT_W]  ),
                .narrow_last  ( out_last[i]                 )
            );
        end else begin : g_wide
            // Full-width port reads the buffer directly
            assign out_valid[i]               = rd_valid;
            assign rd_ready                   = out_ready[i];
            assign out_data[i*OUT_W +: OUT_W] = rd_data[OUT_W-1:0];
            assign out_last[i]                = rd_last;
        end
    end

endmodule

`default_nettype wire

// ==== logic/mpls_label_edit.sv ====
// MPLS label edit stage
// Registers the stream and decrements the top-label TTL on each first beat

`timescale 1ns/1ps
`default_nettype none

module mpls_label_edit (
    input  wire logic                                   clk,
    input  wire logic                                   rst_n,
    input  wire logic                                   in_valid,
    output logic                                        in_ready,
    input  wire logic [mpls_egress_pkg::BUS_W-1:0]      in_data,
    input  wire logic                                   in_last,
    input  wire logic [mpls_egress_pkg::PORT_SEL_W-1:0] in_port,
    output logic                                        edit_valid,
    input  wire logic                                   edit_ready,
    output logic [mpls_egress_pkg::BUS_W-1:0]           edit_data,
    output logic                                        edit_last,
    output logic [mpls_egress_pkg::PORT_SEL_W-1:0]      edit_port
);

    localparam int LSE_W = $bits(mpls_label_pkg::mpls_lse_u);

    mpls_label_pkg::mpls_lse_u           lse_in;
    mpls_label_pkg::mpls_lse_u           lse_out;
    logic [mpls_egress_pkg::BUS_W-1:0]   data_edited;
    logic                                sop;
    logic                                in_xfer;

    // Full register, so take a beat when empty or draining
    assign in_ready = !edit_valid || edit_ready;
    assign in_xfer  = in_valid && in_ready;

    //////////////////////////////////////////////////
    // TTL decrement
    always_comb begin
        lse_in.raw  = in_data[mpls_label_pkg::LSE_LSB +: LSE_W];
        lse_out     = lse_in;
        // Expired label goes out as is
        if (lse_in.lse.ttl != 8'd0) begin
            lse_out.lse.ttl = lse_in.lse.ttl - 8'd1;
        end
        data_edited = in_data;
        if (sop) begin
            data_edited[mpls_label_pkg::LSE_LSB +: LSE_W] = lse_out.raw;
        end
    end

    //////////////////////////////////////////////////
    // Output register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            edit_valid <= 1'b0;
            sop        <= 1'b1;
        end else if (in_xfer) begin
            edit_valid <= 1'b1;
            sop        <= in_last;
        end else if (edit_ready) begin
            edit_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_xfer) begin
            edit_data <= data_edited;
            edit_last <= in_last;
            edit_port <= in_port;
        end
    end

endmodule

`default_nettype wire

// ==== logic/mpls_label_pkg.sv ====
// MPLS label stack entry
// Top entry layout and its place in the first beat

`default_nettype none

package mpls_label_pkg;

    // One 32-bit entry, seen as a raw word or split into fields
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [19:0] label;
            logic [2:0]  tc;
            logic        bos;
            logic [7:0]  ttl;
        } lse;
    } mpls_lse_u;

    // Top label occupies data bits 63:32 of the first beat
    localparam int LSE_LSB = 32;

endpackage

`default_nettype wire

// ==== testbench/mpls_egress_tb.sv ====
// Testbench for the MPLS egress stage
// Routing, TTL edit, port locking, congestion drop and random traffic

`timescale 1ns/1ps
`default_nettype none

module mpls_egress_tb;

    // Far above the few thousand cycles that the tests need
    localparam int MAX_CYCLES = 20000;
    localparam int DRAIN_WAIT = 2000;
    localparam int ADMIT_BEATS =
        mpls_egress_pkg::BUF_DEPTH - mpls_egress_pkg::MAX_PKT_BEATS;

    logic         clk;
    logic         rst_n;
    logic         in_valid;
    logic         in_ready;
    logic [63:0]  in_data;
    logic         in_last;
    logic [1:0]   in_port;
    logic [1:0]   wide_valid;
    logic [127:0] wide_data;
    logic [1:0]   wide_last;
    logic [1:0]   narrow_valid;
    logic [31:0]  narrow_data;
    logic [1:0]   narrow_last;
    logic [3:0]   overflow;
    logic [3:0]   rdy = 4'hF;
    logic [3:0]   hold = 4'h0;
    logic         rand_ready = 1'b0;

    logic [3:0]   out_fire;
    logic [3:0]   out_last;
    logic [63:0]  out_data [4];

    // Expected beats per port as {last, data}, narrow ports in 16-bit slices
    logic [64:0]  exp_q [4][$];
    int           exp_ovf [4];
    int           ovf_cnt [4];
    logic [63:0]  pkt [4];
    mpls_label_pkg::mpls_lse_u top_lse;
    string        test_name = "reset";
    int           errors = 0;
    int           cycles = 0;

    mpls_egress dut (
        .clk          ( clk              ),
        .rst_n        ( rst_n            ),
        .in_valid     ( in_valid         ),
        .in_ready     ( in_ready         ),
        .in_data      ( in_data          ),
        .in_last      ( in_last          ),
        .in_port      ( in_port          ),
        .wide_valid   ( wide_valid       ),
        .wide_ready   ( rdy[1:0]         ),
        .wide_data    ( wide_data        ),
        .wide_last    ( wide_last        ),
        .narrow_valid ( narrow_valid     ),
        .narrow_ready ( rdy[3:2]         ),
        .narrow_data  ( narrow_data      ),
        .narrow_last  ( narrow_last      ),
        .overflow     ( overflow         )
    );

    assign out_fire    = {narrow_valid, wide_valid} & rdy;
    assign out_last    = {narrow_last, wide_last};
    assign out_data[0] = wide_data[63:0];
    assign out_data[1] = wide_data[127:64];
    assign out_data[2] = {48'd0, narrow_data[15:0]};
    assign out_data[3] = {48'd0, narrow_data[31:16]};

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, traffic did not complete", cycles);
            errors++;
            $display("Run finished with %0d errors", errors);
            $display("test failed");
            $finish;
        end
    end

    // Output ready per port, random only in the traffic test
    always @(negedge clk) begin
        for (int p = 0; p < 4; p++) begin
            rdy[p] = hold[p] ? 1'b0 : (rand_ready ? ($urandom % 4 != 0) : 1'b1);
        end
    end

    //////////////////////////////////////////////////
    // Reference model

    // Top TTL sits in the low byte of the entry, so a nonzero TTL never borrows
    function automatic logic [63:0] ttl_ref(input logic [63:0] word);
        mpls_label_pkg::mpls_lse_u lse;
        lse.raw = word[mpls_label_pkg::LSE_LSB +: 32];
        if (lse.lse.ttl == 8'd0) begin
            return word;
        end
        return word - (64'd1 << mpls_label_pkg::LSE_LSB);
    endfunction

    function automatic int outstanding(input int port);
        if (port < mpls_egress_pkg::NUM_WIDE_PORTS) begin
            return exp_q[port].size();
        end
        return (exp_q[port].size() + 3) / 4;
    endfunction

    task automatic expect_pkt(input int port, input int len);
        logic [63:0] word;
        logic        last;
        for (int b = 0; b < len; b++) begin
            word = (b == 0) ? ttl_ref(pkt[b]) : pkt[b];
            last = (b == len - 1);
            if (port < mpls_egress_pkg::NUM_WIDE_PORTS) begin
                exp_q[port].push_back({last, word});
            end else begin
                for (int s = 0; s < 4; s++) begin
                    exp_q[port].push_back({last && (s == 3), 48'd0, word[s*16 +: 16]});
                end
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Stimulus

    task automatic fill_random(input int len);
        for (int b = 0; b < len; b++) begin
            pkt[b] = {$urandom, $urandom};
        end
    endtask

    task automatic send_pkt(input int port, input int len, input int later_port, input bit drop);
        if (drop) begin
            exp_ovf[port]++;
        end else begin
            expect_pkt(port, len);
        end
        for (int b = 0; b < len; b++) begin
            @(negedge clk);
            in_valid = 1'b1;
            in_data  = pkt[b];
            in_last  = (b == len - 1);
            in_port  = (b == 0) ? port[1:0] : later_port[1:0];
            while (!in_ready) begin
                @(negedge clk);
            end
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic close_test();
        int waited;
        waited = 0;
        while ((exp_q[0].size() + exp_q[1].size() + exp_q[2].size() + exp_q[3].size()) != 0
               && waited < DRAIN_WAIT) begin
            @(negedge clk);
            waited++;
        end
        repeat (4) @(negedge clk);
        for (int p = 0; p < 4; p++) begin
            if (exp_q[p].size() != 0) begin
                $display("ERROR %s: port %0d never sent %0d expected beats",
                         test_name, p, exp_q[p].size());
                errors++;
            end
            if (ovf_cnt[p] > exp_ovf[p]) begin
                $display("ERROR %s: unexpected overflow on port %0d", test_name, p);
                errors++;
            end else if (ovf_cnt[p] < exp_ovf[p]) begin
                $display("ERROR %s: missing overflow on port %0d", test_name, p);
                errors++;
            end
            ovf_cnt[p] = exp_ovf[p];
            exp_q[p].delete();
        end
    endtask

    //////////////////////////////////////////////////
    // Monitor and scoreboard
    always @(posedge clk) begin : monitor
        logic [64:0] exp_word;
        if (rst_n) begin
            for (int p = 0; p < 4; p++) begin
                if (overflow[p]) begin
                    ovf_cnt[p]++;
                end
                if (out_fire[p]) begin
                    if (exp_q[p].size() == 0) begin
                        $display("ERROR %s: port %0d sent a beat that was not expected",
                                 test_name, p);
                        errors++;
                    end else begin
                        exp_word = exp_q[p].pop_front();
                        if (exp_word != {out_last[p], out_data[p]}) begin
                            $display("MISMATCH %s port %0d: expected %h actual %h",
                                     test_name, p, exp_word, {out_last[p], out_data[p]});
                            errors++;
                        end
                    end
                end
            end
        end
    end

    initial begin : main
        int port;
        int len;
        void'($urandom(98806));
        in_valid = 1'b0;
        in_data  = '0;
        in_last  = 1'b0;
        in_port  = '0;
        rst_n    = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_name = "routing";
        for (int p = 0; p < 4; p++) begin
            fill_random(3);
            send_pkt(p, 3, p, 1'b0);
        end
        close_test();

        // Expired, last-hop and full TTL, with TTL-like bytes in later beats
        test_name = "ttl_edge";
        top_lse.raw       = 32'h0;
        top_lse.lse.label = 20'hABCDE;
        top_lse.lse.tc    = 3'd5;
        top_lse.lse.bos   = 1'b1;
        for (int t = 0; t < 3; t++) begin
            top_lse.lse.ttl = (t == 0) ? 8'd0 : ((t == 1) ? 8'd1 : 8'hFF);
            pkt[0] = {top_lse.raw, 32'h0000_0001};
            pkt[1] = {32'hFFFF_FF01, 32'h0000_0001};
            pkt[2] = {32'h1234_5600, 32'hFFFF_FF05};
            send_pkt(t, 3, t, 1'b0);
        end
        close_test();

        test_name = "port_lock";
        fill_random(4);
        send_pkt(1, 4, 2, 1'b0);
        fill_random(4);
        send_pkt(3, 4, 0, 1'b0);
        close_test();

        // Port 0 stalled so four packets fill its buffer and the fifth is dropped
        test_name = "congestion";
        hold = 4'b0001;
        for (int i = 0; i < 5; i++) begin
            fill_random(4);
            send_pkt(0, 4, 0, i == 4);
        end
        repeat (10) @(negedge clk);
        hold = 4'b0000;
        close_test();

        test_name = "random";
        rand_ready = 1'b1;
        for (int i = 0; i < 300; i++) begin
            port = $urandom % 4;
            len  = 1 + $urandom % 4;
            fill_random(len);
            while (outstanding(port) + len > ADMIT_BEATS) begin
                @(negedge clk);
            end
            send_pkt(port, len, $urandom % 4, 1'b0);
        end
        rand_ready = 1'b0;
        close_test();

        $display("Run finished with %0d errors", errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
